// ==== source/lpBusPkg.sv ====
// Memory-side widths, memory word, character views union, request and response structs
`default_nettype none

package lpBusPkg;

   ////////////////////
   // Widths
   ////////////////////

   // One word of the 36-bit machine
   localparam int wordWidth = 36;
   // Word address into host memory
   localparam int addrWidth = 18;

   typedef logic [wordWidth-1:0] memWord_t;

   // Four 8-bit characters with four unused bits on top
   typedef struct packed {
      logic [3:0]      spare;
      logic [0:3][7:0] ch;
   } eightBit_t;

   // Five 7-bit characters with one unused bit at the bottom
   typedef struct packed {
      logic [0:4][6:0] ch;
      logic            spare;
   } sevenBit_t;

   // Same 36 bits read either way
   typedef union packed {
      eightBit_t eight;
      sevenBit_t seven;
   } charWord_u;

   ////////////////////
   // Memory port
   ////////////////////

   // Request is a level, address held steady while req is up
   typedef struct packed {
      logic                 req;
      logic [addrWidth-1:0] addr;
   } memReq_t;

   // Single-cycle ack with its data word
   typedef struct packed {
      logic     ack;
      memWord_t data;
   } memRsp_t;

endpackage

`default_nettype wire

// ==== source/lpCsrPkg.sv ====
// Channel count, register map, command and status structs, printer char struct, timing constants
`default_nettype none

package lpCsrPkg;

   ////////////////////
   // Sizes
   ////////////////////

   localparam int numChannels = 3;
   localparam int chanWidth   = 2;
   localparam int countWidth  = 12;
   localparam int regWidth    = 2;
   // Host data path width
   localparam int dataWidth   = 18;
   localparam int timerWidth  = 8;
   // Unused bits between the flags and the count in a status read
   localparam int statusPadWidth = dataWidth - 3 - countWidth;

   // Highest channel index, first to lose priority after reset
   localparam logic [chanWidth-1:0] lastChan = chanWidth'(numChannels - 1);

   // Cycles a request may wait for its ack
   localparam logic [timerWidth-1:0] ackTimeout = 8'd255;

   ////////////////////
   // Register map
   ////////////////////

   localparam logic [regWidth-1:0] regCommand = 2'd0;
   localparam logic [regWidth-1:0] regAddress = 2'd1;
   localparam logic [regWidth-1:0] regCount   = 2'd2;
   localparam logic [regWidth-1:0] regStatus  = 2'd3;

   typedef enum logic {mode8, mode7} charMode_e;

   // go, stop and load fields pulse for one cycle
   typedef struct packed {
      logic                 go;
      logic                 stop;
      logic                 testAckTimeout;
      charMode_e            mode;
      logic                 loadAddr;
      logic                 loadCount;
      logic [dataWidth-1:0] value;
   } chanCmd_t;

   typedef struct packed {
      logic                  running;
      logic                  done;
      logic                  ackError;
      logic [countWidth-1:0] remaining;
   } chanStatus_t;

   // 7-bit characters arrive zero-extended
   typedef struct packed {
      logic       strobe;
      logic [7:0] ch;
   } prtChar_t;

endpackage

`default_nettype wire

// ==== source/lpCommandDecode.sv ====
// Host register write decoder into per-channel command pulses, status read multiplexer
`default_nettype none
`timescale 1ns/1ps

module lpCommandDecode
(
   input  wire                                    clk,
   input  wire                                    rst,
   input  wire                                    csrWrite,
   input  wire logic [lpCsrPkg::chanWidth-1:0]    csrChan,
   input  wire logic [lpCsrPkg::regWidth-1:0]     csrReg,
   input  wire logic [lpCsrPkg::dataWidth-1:0]    csrWriteData,
   input  wire                                    csrRead,
   input  wire lpCsrPkg::chanStatus_t             status [0:lpCsrPkg::numChannels-1],
   output lpCsrPkg::chanCmd_t                     cmd [0:lpCsrPkg::numChannels-1],
   output logic [lpCsrPkg::dataWidth-1:0]         csrReadData
);

   ////////////////////
   // Write side
   ////////////////////

   // Pulses live for one cycle only
   // Only the addressed channel sees anything
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         for (int i = 0; i < lpCsrPkg::numChannels; i++)
            cmd[i] <= '0;
      end
      else
      begin
         for (int i = 0; i < lpCsrPkg::numChannels; i++)
         begin
            cmd[i] <= '0;
            if (csrWrite && int'(csrChan) == i)
            begin
               // Load value rides along with every write
               cmd[i].value <= csrWriteData;
               case (csrReg)
                  lpCsrPkg::regCommand:
                  begin
                     // Command word bits
                     cmd[i].go             <= csrWriteData[0];
                     cmd[i].stop           <= csrWriteData[1];
                     cmd[i].testAckTimeout <= csrWriteData[2];
                     cmd[i].mode           <= lpCsrPkg::charMode_e'(csrWriteData[3]);
                  end
                  lpCsrPkg::regAddress:
                     cmd[i].loadAddr <= 1'b1;
                  lpCsrPkg::regCount:
                     cmd[i].loadCount <= 1'b1;
                  default:
                  begin
                     // Status register is read only
                  end
               endcase
            end
         end
      end
   end

   ////////////////////
   // Read side
   ////////////////////

   // Flags on top, count at the bottom
   // Reads have no side effects
   always_comb
   begin
      lpCsrPkg::chanStatus_t sel;
      sel         = '0;
      csrReadData = '0;
      if (csrRead && csrReg == lpCsrPkg::regStatus && int'(csrChan) < lpCsrPkg::numChannels)
      begin
         sel         = status[csrChan];
         csrReadData = {sel.running, sel.done, sel.ackError,
                        {lpCsrPkg::statusPadWidth{1'b0}}, sel.remaining};
      end
   end

endmodule

`default_nettype wire

// ==== source/lpDma.sv ====
// Single printer channel DMA FSM with address, count, ack timer and character unpacker
`default_nettype none
`timescale 1ns/1ps

module lpDma
(
   input  wire                        clk,
   input  wire                        rst,
   input  wire lpCsrPkg::chanCmd_t    cmd,
   input  wire lpBusPkg::memRsp_t     memRsp,
   input  wire                        printerReady,
   output lpBusPkg::memReq_t          memReq,
   output lpCsrPkg::prtChar_t         prtChar,
   output lpCsrPkg::chanStatus_t      status
);

   typedef enum logic [2:0] {
      stIdle,
      stWaitReady,
      stRead,
      stUnpack,
      stNext,
      stDone,
      stAckFail
   } state_e;

   state_e                                state;
   logic [lpBusPkg::addrWidth-1:0]        addr;
   logic [lpCsrPkg::countWidth-1:0]       remaining;
   logic [lpCsrPkg::timerWidth-1:0]       timer;
   logic [2:0]                            charIdx;
   logic [2:0]                            lastIdx;
   logic                                  req;
   logic                                  running;
   logic                                  done;
   logic                                  ackError;
   logic                                  testAck;
   lpCsrPkg::charMode_e                   mode;
   lpBusPkg::charWord_u                   word;
   logic [7:0]                            curChar;
   logic                                  ackSeen;

   // Ack counts only when not under the timeout test
   assign ackSeen = memRsp.ack && !testAck;

   // Last character slot of a word
   assign lastIdx = (mode == lpCsrPkg::mode8) ? 3'd3 : 3'd4;

   ////////////////////
   // Control FSM
   ////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state     <= stIdle;
         addr      <= '0;
         remaining <= '0;
         timer     <= lpCsrPkg::ackTimeout;
         charIdx   <= '0;
         req       <= 1'b0;
         running   <= 1'b0;
         done      <= 1'b0;
         ackError  <= 1'b0;
         testAck   <= 1'b0;
         mode      <= lpCsrPkg::mode8;
      end
      else if (cmd.stop)
      begin
         // Abort wherever we are, done stays as it was
         state   <= stIdle;
         req     <= 1'b0;
         running <= 1'b0;
      end
      else
      begin
         case (state)
            stIdle:
            begin
               // Setup writes land only while idle
               if (cmd.loadAddr)
                  addr <= cmd.value;
               if (cmd.loadCount)
                  remaining <= cmd.value[lpCsrPkg::countWidth-1:0];
               if (cmd.go)
               begin
                  running  <= 1'b1;
                  done     <= 1'b0;
                  ackError <= 1'b0;
                  mode     <= cmd.mode;
                  testAck  <= cmd.testAckTimeout;
                  // Empty job finishes at once
                  state    <= (remaining == '0) ? stDone : stWaitReady;
               end
            end

            stWaitReady:
               if (printerReady)
               begin
                  req   <= 1'b1;
                  timer <= lpCsrPkg::ackTimeout;
                  state <= stRead;
               end

            stRead:
               if (ackSeen)
               begin
                  req     <= 1'b0;
                  charIdx <= '0;
                  state   <= stUnpack;
               end
               else if (timer == '0)
               begin
                  // Give up on this word
                  req   <= 1'b0;
                  state <= stAckFail;
               end
               else
                  timer <= timer - 1'b1;

            stUnpack:
               // One character per ready cycle
               if (printerReady)
               begin
                  remaining <= remaining - 1'b1;
                  charIdx   <= charIdx + 1'b1;
                  if (remaining == 1 || charIdx == lastIdx)
                     state <= stNext;
               end

            stNext:
            begin
               addr  <= addr + 1'b1;
               state <= (remaining == '0) ? stDone : stWaitReady;
            end

            stAckFail:
            begin
               ackError <= 1'b1;
               state    <= stDone;
            end

            stDone:
            begin
               running <= 1'b0;
               // A failed run is not a finished one
               done    <= !ackError;
               state   <= stIdle;
            end

            default:
               state <= stIdle;
         endcase
      end
   end

   ////////////////////
   // Data word
   ////////////////////

   // Captured on the accepted ack
   always_ff @(posedge clk)
   begin
      if (state == stRead && ackSeen)
         word <= memRsp.data;
   end

   // Pick the current character from the view the mode selects
   always_comb
   begin
      if (mode == lpCsrPkg::mode8)
         curChar = word.eight.ch[charIdx[1:0]];
      else
         curChar = {1'b0, word.seven.ch[charIdx]};
   end

   // Outputs
   assign memReq.req  = req;
   assign memReq.addr = addr;

   // Strobe only in a ready cycle
   assign prtChar.strobe = (state == stUnpack) && printerReady;
   assign prtChar.ch     = curChar;

   assign status.running   = running;
   assign status.done      = done;
   assign status.ackError  = ackError;
   assign status.remaining = remaining;

endmodule

`default_nettype wire

// ==== source/lpMemArbiter.sv ====
// Round-robin memory arbiter with grant-gated response routing
`default_nettype none
`timescale 1ns/1ps

module lpMemArbiter
(
   input  wire                        clk,
   input  wire                        rst,
   input  wire lpBusPkg::memReq_t     chanReq [0:lpCsrPkg::numChannels-1],
   input  wire lpBusPkg::memRsp_t     extRsp,
   output lpBusPkg::memRsp_t          chanRsp [0:lpCsrPkg::numChannels-1],
   output lpBusPkg::memReq_t          extReq
);

   // Grant index doubles as the last channel served
   logic [lpCsrPkg::chanWidth-1:0] grant;
   logic [lpCsrPkg::chanWidth-1:0] pick;
   logic                           busy;
   logic                           found;

   ////////////////////
   // Next requester
   ////////////////////

   // Search starts just past the last grant
   always_comb
   begin
      int idx;
      found = 1'b0;
      pick  = grant;
      for (int k = 1; k <= lpCsrPkg::numChannels; k++)
      begin
         idx = (int'(grant) + k) % lpCsrPkg::numChannels;
         if (!found && chanReq[idx].req)
         begin
            found = 1'b1;
            pick  = idx[lpCsrPkg::chanWidth-1:0];
         end
      end
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         busy   <= 1'b0;
         grant  <= lpCsrPkg::lastChan;
         extReq <= '0;
      end
      else if (busy)
      begin
         // Ack ends the transfer, so does a channel that gave up
         if (extRsp.ack || !chanReq[grant].req)
         begin
            busy   <= 1'b0;
            extReq <= '0;
         end
         else
            extReq <= chanReq[grant];
      end
      else if (found)
      begin
         busy   <= 1'b1;
         grant  <= pick;
         extReq <= chanReq[pick];
      end
   end

   // Response reaches the granted channel only, same cycle
   always_comb
   begin
      for (int i = 0; i < lpCsrPkg::numChannels; i++)
         chanRsp[i] = (busy && int'(grant) == i) ? extRsp : '0;
   end

endmodule

`default_nettype wire

// ==== source/lpPrinterSubsystem.sv ====
// Printer subsystem top with command decoder, channel array and memory arbiter
`default_nettype none
`timescale 1ns/1ps

module lpPrinterSubsystem
(
   input  wire                                    clk,
   input  wire                                    rst,
   input  wire                                    csrWrite,
   input  wire logic [lpCsrPkg::chanWidth-1:0]    csrChan,
   input  wire logic [lpCsrPkg::regWidth-1:0]     csrReg,
   input  wire logic [lpCsrPkg::dataWidth-1:0]    csrWriteData,
   input  wire                                    csrRead,
   output logic [lpCsrPkg::dataWidth-1:0]         csrReadData,
   output lpBusPkg::memReq_t                      memReq,
   input  wire lpBusPkg::memRsp_t                 memRsp,
   input  wire logic [lpCsrPkg::numChannels-1:0]  printerReady,
   output lpCsrPkg::prtChar_t                     prtChar [0:lpCsrPkg::numChannels-1]
);

   // Per-channel wiring
   lpCsrPkg::chanCmd_t    cmd     [0:lpCsrPkg::numChannels-1];
   lpCsrPkg::chanStatus_t status  [0:lpCsrPkg::numChannels-1];
   lpBusPkg::memReq_t     chanReq [0:lpCsrPkg::numChannels-1];
   lpBusPkg::memRsp_t     chanRsp [0:lpCsrPkg::numChannels-1];

   // Host registers
   lpCommandDecode uDecode
   (
      .clk          (clk),
      .rst          (rst),
      .csrWrite     (csrWrite),
      .csrChan      (csrChan),
      .csrReg       (csrReg),
      .csrWriteData (csrWriteData),
      .csrRead      (csrRead),
      .status       (status),
      .cmd          (cmd),
      .csrReadData  (csrReadData)
   );

   // One DMA engine per printer
   for (genvar i = 0; i < lpCsrPkg::numChannels; i++)
   begin : gChan
      lpDma uDma
      (
         .clk          (clk),
         .rst          (rst),
         .cmd          (cmd[i]),
         .memRsp       (chanRsp[i]),
         .printerReady (printerReady[i]),
         .memReq       (chanReq[i]),
         .prtChar      (prtChar[i]),
         .status       (status[i])
      );
   end

   // Shared memory port
   lpMemArbiter uArbiter
   (
      .clk     (clk),
      .rst     (rst),
      .chanReq (chanReq),
      .extRsp  (memRsp),
      .chanRsp (chanRsp),
      .extReq  (memReq)
   );

endmodule

`default_nettype wire

// ==== testbench/lpDmaSva.sv ====
// Bound assertions for one DMA channel: request hold, strobe gating, running and done exclusion
`default_nettype none
`timescale 1ns/1ps

module lpDmaSva
(
   input wire                                 clk,
   input wire                                 rst,
   input wire lpCsrPkg::chanCmd_t             cmd,
   input wire lpBusPkg::memRsp_t              memRsp,
   input wire lpBusPkg::memReq_t              memReq,
   input wire                                 printerReady,
   input wire lpCsrPkg::prtChar_t             prtChar,
   input wire lpCsrPkg::chanStatus_t          status,
   input wire [lpCsrPkg::timerWidth-1:0]      timer,
   input wire                                 testAck
);

   ////////////////////
   // Request
   ////////////////////

   // Held with a steady address until a usable ack, the timeout or a stop
   reqHeld: assert property (@(posedge clk) disable iff (rst)
      (memReq.req && !(memRsp.ack && !testAck) && timer != '0 && !cmd.stop)
      |=> (memReq.req && $stable(memReq.addr)))
      else $error("request dropped or address moved before ack or timeout");

   // Printer side, only while a fetched word is being unpacked
   strobeReady: assert property (@(posedge clk) disable iff (rst)
      prtChar.strobe |-> (printerReady && status.running && !memReq.req))
      else $error("strobe while printer not ready or channel not unpacking");

   // Never both at once
   runDone: assert property (@(posedge clk) disable iff (rst)
      !(status.running && status.done))
      else $error("running and done set together");

endmodule

bind lpDma lpDmaSva uSva
(
   .clk          (clk),
   .rst          (rst),
   .cmd          (cmd),
   .memRsp       (memRsp),
   .memReq       (memReq),
   .printerReady (printerReady),
   .prtChar      (prtChar),
   .status       (status),
   .timer        (timer),
   .testAck      (testAck)
);

`default_nettype wire

// ==== testbench/lpPrinterSubsystemTb.sv ====
// Directed testbench with memory model, printer models, check tasks and six tests
`default_nettype none
`timescale 1ns/1ps

module lpPrinterSubsystemTb;

   localparam int nCh = lpCsrPkg::numChannels;
   localparam int waitLimit = 5000;

   logic                                 clk;
   logic                                 rst;
   logic                                 csrWrite;
   logic [lpCsrPkg::chanWidth-1:0]       csrChan;
   logic [lpCsrPkg::regWidth-1:0]        csrReg;
   logic [lpCsrPkg::dataWidth-1:0]       csrWriteData;
   logic                                 csrRead;
   logic [lpCsrPkg::dataWidth-1:0]       csrReadData;
   lpBusPkg::memReq_t                    memReq;
   lpBusPkg::memRsp_t                    memRsp;
   logic [nCh-1:0]                       printerReady;
   lpCsrPkg::prtChar_t                   prtChar [0:nCh-1];

   // Expected characters per printer, expected addresses for the memory
   lpCsrPkg::prtChar_t                   expQ [0:nCh-1][$];
   logic [lpBusPkg::addrWidth-1:0]       addrQ [$];
   logic                                 trackAddr;
   logic [nCh-1:0]                       hold;
   int                                   printed [0:nCh-1];

   // Memory model state
   logic                                 pending;
   logic [lpBusPkg::addrWidth-1:0]       pendAddr;
   int                                   delay;

   lpPrinterSubsystem UUT
   (
      .clk          (clk),
      .rst          (rst),
      .csrWrite     (csrWrite),
      .csrChan      (csrChan),
      .csrReg       (csrReg),
      .csrWriteData (csrWriteData),
      .csrRead      (csrRead),
      .csrReadData  (csrReadData),
      .memReq       (memReq),
      .memRsp       (memRsp),
      .printerReady (printerReady),
      .prtChar      (prtChar)
   );

   always #2 clk = ~clk;

   ////////////////////
   // Helpers
   ////////////////////

   task automatic failRun(input string msg);
      $display("%s", msg);
      $display("CHECKS FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic failValue(input string msg);
      failRun($sformatf("FAILED at %0t ns: %s", $time, msg));
   endtask

   task automatic checkChar(input lpCsrPkg::prtChar_t got, input lpCsrPkg::prtChar_t exp);
      if (got !== exp)
         failValue($sformatf("char got %0h expected %0h", got.ch, exp.ch));
   endtask

   task automatic checkStatus(input lpCsrPkg::chanStatus_t got,
                              input lpCsrPkg::chanStatus_t exp);
      if (got !== exp)
         failValue($sformatf("status got r%0b d%0b e%0b n%0d expected r%0b d%0b e%0b n%0d",
                   got.running, got.done, got.ackError, got.remaining,
                   exp.running, exp.done, exp.ackError, exp.remaining));
   endtask

   task automatic checkAddr(input logic [lpBusPkg::addrWidth-1:0] got,
                            input logic [lpBusPkg::addrWidth-1:0] exp);
      if (got !== exp)
         failValue($sformatf("memory address got %0h expected %0h", got, exp));
   endtask

   // Test pattern word, every address bit matters
   function automatic lpBusPkg::memWord_t wordAt(input logic [lpBusPkg::addrWidth-1:0] a);
      return {a * 18'd3 + 18'h0a5f1, a ^ 18'h3c96e};
   endfunction

   // Queue the characters and word addresses a job should produce
   task automatic expectJob(input int c, input int a, input int n, input bit seven);
      int per;
      lpBusPkg::memWord_t w;
      lpCsrPkg::prtChar_t pc;
      per = seven ? 5 : 4;
      for (int k = 0; k < (n + per - 1) / per; k++)
         addrQ.push_back(lpBusPkg::addrWidth'(a + k));
      for (int i = 0; i < n; i++)
      begin
         w = wordAt(lpBusPkg::addrWidth'(a + i / per));
         pc.strobe = 1'b1;
         // Character 0 sits in the high bits
         if (seven)
            pc.ch = {1'b0, w[35 - 7 * (i % per) -: 7]};
         else
            pc.ch = w[31 - 8 * (i % per) -: 8];
         expQ[c].push_back(pc);
      end
   endtask

   task automatic writeReg(input int c, input logic [1:0] r, input int data);
      @(negedge clk);
      csrRead      = 1'b0;
      csrWrite     = 1'b1;
      csrChan      = lpCsrPkg::chanWidth'(c);
      csrReg       = r;
      csrWriteData = lpCsrPkg::dataWidth'(data);
      @(negedge clk);
      csrWrite     = 1'b0;
   endtask

   // Status read is combinational, sampled mid cycle
   task automatic readStatus(input int c, output lpCsrPkg::chanStatus_t s);
      @(negedge clk);
      csrRead = 1'b1;
      csrChan = lpCsrPkg::chanWidth'(c);
      csrReg  = lpCsrPkg::regStatus;
      #1;
      s.running   = csrReadData[17];
      s.done      = csrReadData[16];
      s.ackError  = csrReadData[15];
      s.remaining = csrReadData[lpCsrPkg::countWidth-1:0];
   endtask

   task automatic waitRunning(input int c, input bit level);
      lpCsrPkg::chanStatus_t s;
      int t;
      t = 0;
      readStatus(c, s);
      while (s.running != level)
      begin
         t++;
         if (t > waitLimit)
            failRun($sformatf("timeout waiting for running=%0b on channel %0d", level, c));
         readStatus(c, s);
      end
   endtask

   task automatic startJob(input int c, input int a, input int n, input int cmdBits);
      writeReg(c, lpCsrPkg::regAddress, a);
      writeReg(c, lpCsrPkg::regCount, n);
      writeReg(c, lpCsrPkg::regCommand, cmdBits);
      waitRunning(c, 1'b1);
   endtask

   // Finished cleanly with all characters and words consumed
   task automatic expectFinished(input int c);
      lpCsrPkg::chanStatus_t s;
      waitRunning(c, 1'b0);
      readStatus(c, s);
      checkStatus(s, '{running: 1'b0, done: 1'b1, ackError: 1'b0, remaining: '0});
      if (expQ[c].size() != 0)
         failRun($sformatf("channel %0d missed %0d characters", c, expQ[c].size()));
   endtask

   ////////////////////
   // Memory model
   ////////////////////

   always @(negedge clk)
   begin
      if (!rst)
      begin
         if (memRsp.ack)
            memRsp = '0;
         else if (pending)
         begin
            // Arbiter abandoned the request
            if (!memReq.req)
               pending = 1'b0;
            else if (delay == 0)
            begin
               memRsp.ack  = 1'b1;
               memRsp.data = wordAt(pendAddr);
               pending     = 1'b0;
            end
            else
               delay--;
         end
         else if (memReq.req)
         begin
            pending  = 1'b1;
            pendAddr = memReq.addr;
            delay    = $urandom % 20;
            if (trackAddr)
            begin
               int idx;
               idx = -1;
               foreach (addrQ[k])
                  if (idx < 0 && addrQ[k] == pendAddr)
                     idx = k;
               if (idx < 0)
                  checkAddr(pendAddr, (addrQ.size() != 0) ? addrQ[0] : ~pendAddr);
               else
                  addrQ.delete(idx);
            end
         end
      end
   end

   // Printers pick the next ready level, then catch the strobe it lets out
   always @(negedge clk)
   begin
      for (int c = 0; c < nCh; c++)
         printerReady[c] = hold[c] ? 1'b0 : (($urandom % 4) != 0);
      #1;
      for (int c = 0; c < nCh; c++)
      begin
         if (prtChar[c].strobe)
         begin
            if (expQ[c].size() == 0)
               failRun($sformatf("unexpected strobe on channel %0d", c));
            else
               checkChar(prtChar[c], expQ[c].pop_front());
            printed[c]++;
         end
      end
   end

   ////////////////////
   // Tests
   ////////////////////

   task automatic testReset();
      lpCsrPkg::chanStatus_t s;
      for (int c = 0; c < nCh; c++)
      begin
         readStatus(c, s);
         checkStatus(s, '0);
      end
      for (int i = 0; i < 20; i++)
      begin
         @(negedge clk);
         if (memReq.req)
            failRun("memory request seen after reset");
      end
   endtask

   task automatic testMode8();
      expectJob(0, 'h20, 10, 1'b0);
      startJob(0, 'h20, 10, 'h1);
      expectFinished(0);
   endtask

   task automatic testMode7();
      expectJob(0, 'h40, 7, 1'b1);
      startJob(0, 'h40, 7, 'h9);
      expectFinished(0);
   endtask

   task automatic testAllChannels();
      expectJob(0, 'h100, 9, 1'b0);
      expectJob(1, 'h200, 11, 1'b1);
      expectJob(2, 'h300, 6, 1'b0);
      startJob(0, 'h100, 9, 'h1);
      startJob(1, 'h200, 11, 'h9);
      startJob(2, 'h300, 6, 'h1);
      for (int c = 0; c < nCh; c++)
         expectFinished(c);
      if (addrQ.size() != 0)
         failRun($sformatf("%0d memory words never requested", addrQ.size()));
   endtask

   task automatic testAckTimeout();
      lpCsrPkg::chanStatus_t s;
      // Same word is requested again and again
      trackAddr = 1'b0;
      startJob(2, 'h50, 4, 'h5);
      waitRunning(2, 1'b0);
      readStatus(2, s);
      checkStatus(s, '{running: 1'b0, done: 1'b0, ackError: 1'b1, remaining: 12'd4});
      trackAddr = 1'b1;
   endtask

   task automatic testStop();
      lpCsrPkg::chanStatus_t s;
      int t;
      // Count only this job's characters
      printed[1] = 0;
      expectJob(1, 'h400, 40, 1'b0);
      startJob(1, 'h400, 40, 'h1);
      t = 0;
      while (printed[1] < 6)
      begin
         @(negedge clk);
         t++;
         if (t > waitLimit)
            failRun("timeout waiting for characters before stop");
      end
      // Freeze the printer so nothing prints around the stop
      hold[1] = 1'b1;
      repeat (2) @(negedge clk);
      writeReg(1, lpCsrPkg::regCommand, 'h2);
      waitRunning(1, 1'b0);
      expQ[1].delete();
      addrQ.delete();
      hold[1] = 1'b0;
      repeat (60) @(negedge clk);
      readStatus(1, s);
      checkStatus(s, '{running: 1'b0, done: 1'b0, ackError: 1'b0,
                       remaining: lpCsrPkg::countWidth'(40 - printed[1])});
   endtask

   initial
   begin
      void'($urandom(32'h45a7763e));
      clk          = 1'b0;
      rst          = 1'b1;
      csrWrite     = 1'b0;
      csrChan      = '0;
      csrReg       = '0;
      csrWriteData = '0;
      csrRead      = 1'b0;
      memRsp       = '0;
      printerReady = '0;
      hold         = '0;
      trackAddr    = 1'b1;
      pending      = 1'b0;
      pendAddr     = '0;
      delay        = 0;
      for (int c = 0; c < nCh; c++)
         printed[c] = 0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      testReset();
      testMode8();
      testMode7();
      testAllChannels();
      testAckTimeout();
      testStop();

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/lpBusPkg.sv
source/lpCsrPkg.sv
source/lpCommandDecode.sv
source/lpDma.sv
source/lpMemArbiter.sv
source/lpPrinterSubsystem.sv
testbench/lpDmaSva.sv
testbench/lpPrinterSubsystemTb.sv

// ==== Makefile ====
# Verilator build and run for the printer subsystem testbench

VERILATOR ?= verilator
TOP       ?= lpPrinterSubsystemTb
OBJ_DIR   ?= obj_dir
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
